// File: logic/IntCorePkg.sv
// ============================================================
// Integer back end shared definitions
// Widths, operand and ALU encodings, the operand-immediate
// union and the pipeline register layouts
// ============================================================
package IntCorePkg;

    localparam int DataWidth = 32;
    localparam int PRegNumWidth = 5;
    localparam int ImmFieldWidth = 21;
    localparam int NumPRegs = 1 << PRegNumWidth;

    typedef logic [DataWidth-1:0] DataPath;
    typedef logic [PRegNumWidth-1:0] PRegNum;

    typedef enum logic [1:0] {
        oprReg = 2'd0,
        oprImm = 2'd1,
        oprPc  = 2'd2
    } OpOperandType;

    typedef enum logic {
        immI = 1'b0,
        immU = 1'b1
    } ImmType;

    typedef enum logic [3:0] {
        aluAdd  = 4'd0,
        aluSub  = 4'd1,
        aluAnd  = 4'd2,
        aluOr   = 4'd3,
        aluXor  = 4'd4,
        aluSll  = 4'd5,
        aluSr   = 4'd6,
        aluSlt  = 4'd7,
        aluSltu = 4'd8
    } IntAluCode;

    // Immediate view, read at register read
    typedef struct packed {
        ImmType                   immType;
        logic [ImmFieldWidth-2:0] imm;
    } IntImmView;

    // Shift view, read in execution
    typedef struct packed {
        logic [ImmFieldWidth-7:0] reserved;
        logic                     arith;
        logic [4:0]               shamt;
    } IntShiftView;

    typedef union packed {
        IntImmView   immView;
        IntShiftView shiftView;
    } IntOperandImmShift;

    typedef struct packed {
        logic              valid;
        IntAluCode         aluCode;
        OpOperandType      operandTypeA;
        OpOperandType      operandTypeB;
        IntOperandImmShift immShift;
        PRegNum            srcRegA;
        PRegNum            srcRegB;
        PRegNum            dstReg;
        logic              writeReg;
        DataPath           pc;
    } IntMicroOp;

    typedef enum logic [1:0] {
        bypNone = 2'd0,
        bypWb   = 2'd1,
        bypLast = 2'd2
    } BypassSelect;

    typedef struct packed {
        BypassSelect selA;
        BypassSelect selB;
    } BypassCtrl;

    // Contents of the execution pipeline register
    typedef struct packed {
        logic      valid;
        IntMicroOp op;
        DataPath   operandA;
        DataPath   operandB;
        BypassCtrl bCtrl;
    } IntExecRegPath;

    // Writeback register, also the external result
    typedef struct packed {
        logic    valid;
        logic    writeReg;
        PRegNum  dstReg;
        DataPath data;
    } IntWbRegPath;

endpackage

// File: logic/IntegerRegisterFile.sv
// ============================================================
// Integer physical register file
// 32 entries, two combinational reads, one write port,
// entry zero always reads as zero
// ============================================================
`timescale 1ns/1ps

module IntegerRegisterFile
    import IntCorePkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  PRegNum      rdRegA,
    input  PRegNum      rdRegB,
    input  IntWbRegPath wb,
    input  logic        stall,
    output DataPath     rdDataA,
    output DataPath     rdDataB
);

    // No storage behind entry zero
    DataPath regs [1:NumPRegs-1];
    logic    writeEn;

    assign writeEn = wb.valid && wb.writeReg && !stall && (wb.dstReg != '0);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < NumPRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[wb.dstReg] <= wb.data;
        end
    end

    assign rdDataA = (rdRegA == '0) ? '0 : regs[rdRegA];
    assign rdDataB = (rdRegB == '0) ? '0 : regs[rdRegB];

endmodule

// File: logic/BypassNetwork.sv
// ============================================================
// Bypass network
// Matches register-read sources against in-flight results
// and keeps writeback data for one more enabled cycle
// ============================================================
`timescale 1ns/1ps

module BypassNetwork
    import IntCorePkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  logic        stall,
    input  PRegNum      rrSrcA,
    input  PRegNum      rrSrcB,
    input  logic        rrReadA,
    input  logic        rrReadB,
    input  IntMicroOp   exOp,
    input  IntWbRegPath wb,
    output BypassCtrl   bCtrl,
    output DataPath     lastData
);

    logic exProduces;
    logic wbProduces;

    // The younger producer, the one in execution, is checked first
    function automatic BypassSelect selectSource(
        input logic   readReg,
        input PRegNum src,
        input logic   exHit,
        input PRegNum exDst,
        input logic   wbHit,
        input PRegNum wbDst
    );
        BypassSelect sel;
        sel = bypNone;
        if (readReg && exHit && (src == exDst)) begin
            sel = bypWb;
        end else if (readReg && wbHit && (src == wbDst)) begin
            sel = bypLast;
        end
        return sel;
    endfunction

    // Nonzero destination keeps register zero out of bypassing
    assign exProduces = exOp.valid && exOp.writeReg && (exOp.dstReg != '0);
    assign wbProduces = wb.valid && wb.writeReg && (wb.dstReg != '0);

    always_comb begin
        bCtrl.selA = selectSource(rrReadA, rrSrcA, exProduces, exOp.dstReg,
                                  wbProduces, wb.dstReg);
        bCtrl.selB = selectSource(rrReadB, rrSrcB, exProduces, exOp.dstReg,
                                  wbProduces, wb.dstReg);
    end

    // Same edge as the register file write
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            lastData <= '0;
        end else if (!stall) begin
            lastData <= wb.data;
        end
    end

endmodule

// File: logic/IntegerRegisterReadStage.sv
// ============================================================
// Integer register read stage
// Holds the issued op, reads the register file and selects
// register, immediate or PC for each operand
// ============================================================
`timescale 1ns/1ps

module IntegerRegisterReadStage
    import IntCorePkg::*;
(
    input  logic          clk,
    input  logic          rstN,
    input  IntMicroOp     issueOp,
    input  logic          stall,
    input  logic          clear,
    input  DataPath       rdDataA,
    input  DataPath       rdDataB,
    input  BypassCtrl     bCtrl,
    output PRegNum        srcRegA,
    output PRegNum        srcRegB,
    output logic          rrReadA,
    output logic          rrReadB,
    output PRegNum        rrSrcA,
    output PRegNum        rrSrcB,
    output IntExecRegPath nextStage
);

    logic      rrValid;
    IntMicroOp rrOp;
    DataPath   immValue;
    DataPath   operandA;
    DataPath   operandB;

    function automatic DataPath decodeImm(input IntOperandImmShift field);
        DataPath value;
        if (field.immView.immType == immU) begin
            value = {field.immView.imm[19:0], 12'h000};
        end else begin
            value = {{12{field.immView.imm[19]}}, field.immView.imm[19:0]};
        end
        return value;
    endfunction

    function automatic DataPath selectOperand(
        input OpOperandType opType,
        input DataPath      regValue,
        input DataPath      immValue,
        input DataPath      pcValue
    );
        DataPath value;
        case (opType)
            oprImm:  value = immValue;
            oprPc:   value = pcValue;
            default: value = regValue;
        endcase
        return value;
    endfunction

    // Clear drops the op accepted at the same edge
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            rrValid <= 1'b0;
        end else if (clear) begin
            rrValid <= 1'b0;
        end else if (!stall) begin
            rrValid <= issueOp.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            rrOp <= issueOp;
        end
    end

    // Register file and bypass lookups
    assign srcRegA = rrOp.srcRegA;
    assign srcRegB = rrOp.srcRegB;
    assign rrSrcA  = rrOp.srcRegA;
    assign rrSrcB  = rrOp.srcRegB;
    assign rrReadA = rrValid && (rrOp.operandTypeA == oprReg);
    assign rrReadB = rrValid && (rrOp.operandTypeB == oprReg);

    always_comb begin
        immValue = decodeImm(rrOp.immShift);
        operandA = selectOperand(rrOp.operandTypeA, rdDataA, immValue, rrOp.pc);
        operandB = selectOperand(rrOp.operandTypeB, rdDataB, immValue, rrOp.pc);
    end

    always_comb begin
        nextStage.valid    = rrValid && !stall && !clear;
        nextStage.op       = rrOp;
        nextStage.op.valid = rrValid && !stall && !clear;
        nextStage.operandA = operandA;
        nextStage.operandB = operandB;
        nextStage.bCtrl    = bCtrl;
    end

endmodule

// File: logic/IntegerExecutionStage.sv
// ============================================================
// Integer execution stage
// Applies bypass selects, runs the ALU and holds the
// writeback register that drives the result
// ============================================================
`timescale 1ns/1ps

module IntegerExecutionStage
    import IntCorePkg::*;
(
    input  logic          clk,
    input  logic          rstN,
    input  logic          stall,
    input  logic          clear,
    input  IntExecRegPath prev,
    input  DataPath       lastData,
    output IntMicroOp     exOp,
    output IntWbRegPath   wb
);

    logic          exValid;
    IntExecRegPath exReg;
    DataPath       operandA;
    DataPath       operandB;
    DataPath       aluResult;

    logic          wbValid;
    logic          wbWriteReg;
    PRegNum        wbDst;
    DataPath       wbData;

    function automatic DataPath bypassOperand(
        input BypassSelect sel,
        input DataPath     captured,
        input DataPath     wbValue,
        input DataPath     lastValue
    );
        DataPath value;
        case (sel)
            bypWb:   value = wbValue;
            bypLast: value = lastValue;
            default: value = captured;
        endcase
        return value;
    endfunction

    function automatic DataPath intAlu(
        input IntAluCode code,
        input DataPath   a,
        input DataPath   b,
        input logic      arith
    );
        DataPath    value;
        logic [4:0] shamt;
        shamt = b[4:0];
        case (code)
            aluSub:  value = a - b;
            aluAnd:  value = a & b;
            aluOr:   value = a | b;
            aluXor:  value = a ^ b;
            aluSll:  value = a << shamt;
            aluSr: begin
                if (arith) begin
                    value = $signed(a) >>> shamt;
                end else begin
                    value = a >> shamt;
                end
            end
            aluSlt:  value = {{(DataWidth-1){1'b0}}, $signed(a) < $signed(b)};
            aluSltu: value = {{(DataWidth-1){1'b0}}, a < b};
            default: value = a + b;
        endcase
        return value;
    endfunction

    // Clear also empties the stage while stalled
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exValid <= 1'b0;
        end else if (clear) begin
            exValid <= 1'b0;
        end else if (!stall) begin
            exValid <= prev.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            exReg <= prev;
        end
    end

    always_comb begin
        operandA  = bypassOperand(exReg.bCtrl.selA, exReg.operandA, wbData, lastData);
        operandB  = bypassOperand(exReg.bCtrl.selB, exReg.operandB, wbData, lastData);
        aluResult = intAlu(exReg.op.aluCode, operandA, operandB,
                           exReg.op.immShift.shiftView.arith);
    end

    always_comb begin
        exOp       = exReg.op;
        exOp.valid = exValid;
    end

    // Op in writeback is not squashed by clear
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            wbValid <= 1'b0;
        end else if (!stall) begin
            wbValid <= exValid && !clear;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            wbWriteReg <= exReg.op.writeReg;
            wbDst      <= exReg.op.dstReg;
            wbData     <= aluResult;
        end
    end

    // Held result is reported once, on the unstalled cycle
    always_comb begin
        wb.valid    = wbValid && !stall;
        wb.writeReg = wbWriteReg;
        wb.dstReg   = wbDst;
        wb.data     = wbData;
    end

endmodule

// File: logic/IntegerBackEnd.sv
// ============================================================
// Integer back end top level
// Register read, execution and writeback around a shared
// register file and bypass network
// ============================================================
`timescale 1ns/1ps

module IntegerBackEnd
    import IntCorePkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  IntMicroOp   issueOp,
    input  logic        stall,
    input  logic        clear,
    output IntWbRegPath result
);

    PRegNum        srcRegA;
    PRegNum        srcRegB;
    DataPath       rdDataA;
    DataPath       rdDataB;
    logic          rrReadA;
    logic          rrReadB;
    PRegNum        rrSrcA;
    PRegNum        rrSrcB;
    BypassCtrl     bCtrl;
    DataPath       lastData;
    IntExecRegPath rrToEx;
    IntMicroOp     exOp;
    IntWbRegPath   wbPath;

    IntegerRegisterReadStage rrStage (
        .clk       (clk),
        .rstN      (rstN),
        .issueOp   (issueOp),
        .stall     (stall),
        .clear     (clear),
        .rdDataA   (rdDataA),
        .rdDataB   (rdDataB),
        .bCtrl     (bCtrl),
        .srcRegA   (srcRegA),
        .srcRegB   (srcRegB),
        .rrReadA   (rrReadA),
        .rrReadB   (rrReadB),
        .rrSrcA    (rrSrcA),
        .rrSrcB    (rrSrcB),
        .nextStage (rrToEx)
    );

    IntegerRegisterFile regFile (
        .clk     (clk),
        .rstN    (rstN),
        .rdRegA  (srcRegA),
        .rdRegB  (srcRegB),
        .wb      (wbPath),
        .stall   (stall),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB)
    );

    BypassNetwork bypass (
        .clk      (clk),
        .rstN     (rstN),
        .stall    (stall),
        .rrSrcA   (rrSrcA),
        .rrSrcB   (rrSrcB),
        .rrReadA  (rrReadA),
        .rrReadB  (rrReadB),
        .exOp     (exOp),
        .wb       (wbPath),
        .bCtrl    (bCtrl),
        .lastData (lastData)
    );

    IntegerExecutionStage exStage (
        .clk      (clk),
        .rstN     (rstN),
        .stall    (stall),
        .clear    (clear),
        .prev     (rrToEx),
        .lastData (lastData),
        .exOp     (exOp),
        .wb       (wbPath)
    );

    assign result = wbPath;

endmodule

// File: verif/IntBackEndTb.sv
// ============================================================
// Integer back end testbench
// Random ops from an LFSR, checked against a reference model
// that tracks stage occupancy, stall and clear
// ============================================================
`timescale 1ns/1ps

module IntBackEndTb
    import IntCorePkg::*;
();

    localparam logic [31:0] Seed = 32'h313f;
    localparam int ResetCycles = 16;
    localparam int IdleCycles = 20;
    localparam int OperandCycles = 300;
    localparam int BypassCycles = 300;
    localparam int StallCycles = 300;
    localparam int ClearCycles = 400;
    localparam int TotalCycles = ResetCycles + IdleCycles + OperandCycles
                                 + BypassCycles + StallCycles + ClearCycles;
    localparam int TimeoutCycles = 4 * TotalCycles;

    // One outstanding op and the register value it overwrote
    typedef struct packed {
        logic    writeReg;
        PRegNum  dstReg;
        DataPath data;
        DataPath priorData;
    } ExpectEntry;

    logic        clk;
    logic        rstN;
    IntMicroOp   issueOp;
    logic        stall;
    logic        clear;
    IntWbRegPath result;

    logic [31:0] lfsrState;
    DataPath     modelRegs [0:NumPRegs-1];
    ExpectEntry  expected [$];
    logic        rrOcc;
    logic        exOcc;
    logic        wbOcc;
    int          cycleCount = 0;

    IntegerBackEnd dut0 (
        .clk     (clk),
        .rstN    (rstN),
        .issueOp (issueOp),
        .stall   (stall),
        .clear   (clear),
        .result  (result)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("timeout: the run went past %0d cycles", TimeoutCycles);
            $display("Some tests failed");
            $fatal(1, "run did not finish in time");
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randomBits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic OpOperandType randomOperandType();
        logic [31:0] bits;
        bits = randomBits(2);
        return (bits[1:0] == 2'd3) ? oprReg : OpOperandType'(bits[1:0]);
    endfunction

    function automatic IntMicroOp randomOp(input logic opsOn, input int regBits);
        IntMicroOp   op;
        logic [31:0] bits;
        op = '0;
        op.valid = opsOn && (randomBits(3) != 0);
        bits = randomBits(4);
        op.aluCode = IntAluCode'(bits[3:0] % 4'd9);
        op.operandTypeA = randomOperandType();
        op.operandTypeB = randomOperandType();
        bits = randomBits(21);
        op.immShift = bits[20:0];
        op.srcRegA = PRegNum'(randomBits(regBits));
        op.srcRegB = PRegNum'(randomBits(regBits));
        op.dstReg = PRegNum'(randomBits(regBits));
        op.writeReg = (randomBits(2) != 0);
        op.pc = randomBits(32);
        return op;
    endfunction

    function automatic DataPath operandValue(input OpOperandType t, input PRegNum src,
                                             input IntMicroOp op);
        DataPath imm;
        if (op.immShift.immView.immType == immU) begin
            imm = {op.immShift.immView.imm, 12'h000};
        end else begin
            imm = {{12{op.immShift.immView.imm[19]}}, op.immShift.immView.imm};
        end
        if (t == oprImm) begin
            return imm;
        end else if (t == oprPc) begin
            return op.pc;
        end
        return modelRegs[src];
    endfunction

    function automatic DataPath expectedResult(input IntMicroOp op);
        DataPath a;
        DataPath b;
        DataPath value;
        a = operandValue(op.operandTypeA, op.srcRegA, op);
        b = operandValue(op.operandTypeB, op.srcRegB, op);
        case (op.aluCode)
            aluAdd:  value = a + b;
            aluSub:  value = a - b;
            aluAnd:  value = a & b;
            aluOr:   value = a | b;
            aluXor:  value = a ^ b;
            aluSll:  value = a << b[4:0];
            aluSr: begin
                // Arithmetic bit comes from the shift view of the same field
                if (op.immShift.shiftView.arith) begin
                    value = DataPath'($signed(a) >>> b[4:0]);
                end else begin
                    value = a >> b[4:0];
                end
            end
            aluSlt:  value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            aluSltu: value = (a < b) ? 32'd1 : 32'd0;
            default: value = '0;
        endcase
        return value;
    endfunction

    task automatic checkValue(input logic [31:0] actual, input logic [31:0] expectedValue,
                              input string what);
        if (actual !== expectedValue) begin
            $display("error at %0t: %s is %h, expected %h", $time, what, actual,
                     expectedValue);
            $display("Some tests failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic acceptOp(input IntMicroOp op);
        ExpectEntry e;
        e.writeReg = op.writeReg;
        e.dstReg = op.dstReg;
        e.data = expectedResult(op);
        e.priorData = modelRegs[op.dstReg];
        // Register zero keeps reading zero
        if (op.writeReg && (op.dstReg != '0)) begin
            modelRegs[op.dstReg] = e.data;
        end
        expected.push_back(e);
    endtask

    // Squashed ops are always the youngest ones outstanding
    task automatic dropNewest();
        ExpectEntry e;
        e = expected.pop_back();
        modelRegs[e.dstReg] = e.priorData;
    endtask

    task automatic checkResult();
        ExpectEntry e;
        checkValue(32'(result.valid), 32'(wbOcc && !stall), "result valid");
        if (result.valid) begin
            if (expected.size() == 0) begin
                $display("a result came out at %0t with no op outstanding", $time);
                $display("Some tests failed");
                $fatal(1, "unexpected result");
            end else begin
                e = expected.pop_front();
                checkValue(result.data, e.data, "result data");
                checkValue(32'(result.dstReg), 32'(e.dstReg), "result dstReg");
                checkValue(32'(result.writeReg), 32'(e.writeReg), "result writeReg");
            end
        end
    endtask

    // Occupancy update for the coming rising edge
    task automatic advanceModel();
        if (clear) begin
            if (rrOcc) begin
                dropNewest();
            end
            if (exOcc) begin
                dropNewest();
            end
            rrOcc = 1'b0;
            exOcc = 1'b0;
            if (!stall) begin
                wbOcc = 1'b0;
            end
        end else if (!stall) begin
            wbOcc = exOcc;
            exOcc = rrOcc;
            rrOcc = issueOp.valid;
            if (issueOp.valid) begin
                acceptOp(issueOp);
            end
        end
    endtask

    task automatic driveCycle(input logic opsOn, input int regBits, input logic stallOn,
                              input logic clearOn);
        @(negedge clk);
        // A stalled op is held by the source
        if (!stall) begin
            issueOp = randomOp(opsOn, regBits);
        end
        stall = stallOn && (randomBits(2) == 0);
        clear = clearOn && (randomBits(4) == 0);
        #1;
        checkResult();
        advanceModel();
    endtask

    task automatic runCycles(input int n, input logic opsOn, input int regBits,
                             input logic stallOn, input logic clearOn);
        repeat (n) begin
            driveCycle(opsOn, regBits, stallOn, clearOn);
        end
    endtask

    initial begin
        clk = 1'b0;
        rstN = 1'b0;
        issueOp = '0;
        stall = 1'b0;
        clear = 1'b0;
        lfsrState = Seed;
        rrOcc = 1'b0;
        exOcc = 1'b0;
        wbOcc = 1'b0;
        for (int i = 0; i < NumPRegs; i++) begin
            modelRegs[i] = '0;
        end
        repeat (ResetCycles) @(negedge clk);
        rstN = 1'b1;

        runCycles(IdleCycles, 1'b0, 4, 1'b0, 1'b0);
        // All 32 registers in use
        runCycles(OperandCycles, 1'b1, 5, 1'b0, 1'b0);
        // Few registers so that close dependencies are common
        runCycles(BypassCycles, 1'b1, 2, 1'b0, 1'b0);
        runCycles(StallCycles, 1'b1, 2, 1'b1, 1'b0);
        runCycles(ClearCycles, 1'b1, 3, 1'b1, 1'b1);

        while ((expected.size() != 0) || rrOcc || exOcc || wbOcc) begin
            driveCycle(1'b0, 4, 1'b0, 1'b0);
        end
        runCycles(4, 1'b0, 4, 1'b0, 1'b0);
        $display("All tests passed");
        $finish;
    end

endmodule

// File: flist.f
logic/IntCorePkg.sv
logic/IntegerRegisterFile.sv
logic/BypassNetwork.sv
logic/IntegerRegisterReadStage.sv
logic/IntegerExecutionStage.sv
logic/IntegerBackEnd.sv
verif/IntBackEndTb.sv

// File: Makefile
# Verilator build for the integer back end
# make lint   checks the RTL and testbench
# make sim    builds and runs the testbench, failing on a test error
# make clean  removes build output

TOP = IntBackEndTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --top-module $(TOP) -f flist.f -o simv
	./obj_dir/simv

clean:
	rm -rf obj_dir
